// ==== sources.f ====
verilog/lsu_pkg.sv
verilog/dmem_pkg.sv
verilog/mem_op_decode.sv
verilog/load_unit.sv
verilog/store_queue.sv
verilog/dmem_arbiter.sv
verilog/dmem_model.sv
verilog/lsu_top.sv
tb/lsu_tb.sv

// ==== tb/lsu_tb.sv ====
module lsu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int     stq_depth   = 4;
    localparam int     mem_words   = 256;
    localparam int     mem_latency = 2;
    localparam int     clk_period  = 8;
    localparam longint watchdog_ns = 2000 * clk_period + 500;

    logic            clk = 1'b0;
    logic            rst;
    logic            issue_valid;
    logic            issue_ready;
    lsu_pkg::instr_u instr;
    dmem_pkg::data_t rs1_val;
    dmem_pkg::data_t rs2_val;
    lsu_pkg::tag_t   tag;
    logic            commit;
    logic            backend_flush;
    logic            load_done;
    lsu_pkg::tag_t   load_tag;
    dmem_pkg::data_t load_data;

    logic [7:0]      ref_mem [mem_words*4]; // committed memory image, one byte per entry.
    dmem_pkg::addr_t pend_addr [$];         // issued stores not yet committed.
    int              pend_size [$];
    dmem_pkg::data_t pend_data [$];
    int              mismatches = 0;
    int              failures = 0;
    lsu_pkg::tag_t   next_tag = '0;

    lsu_top #(
        .STQ_DEPTH(stq_depth),
        .MEM_WORDS(mem_words),
        .MEM_LATENCY(mem_latency)
    ) DUT (.*);

    always #(clk_period / 2) clk = ~clk;

    function automatic lsu_pkg::instr_u encode_load(input lsu_pkg::funct3_t f3,
                                                    input logic [11:0] imm);
        return {imm, 5'd2, f3, 5'd10, 7'b0000011};
    endfunction

    function automatic lsu_pkg::instr_u encode_store(input lsu_pkg::funct3_t f3,
                                                     input logic [11:0] imm);
        return {imm[11:5], 5'd3, 5'd2, f3, imm[4:0], 7'b0100011};
    endfunction

    // rs1 value that lands on addr after the immediate is added.
    function automatic dmem_pkg::data_t base_for(input dmem_pkg::addr_t addr,
                                                 input logic [11:0] imm);
        return addr - {{20{imm[11]}}, imm};
    endfunction

    function automatic lsu_pkg::funct3_t random_funct3(input int choices);
        case ($urandom % choices)
            0:       return lsu_pkg::funct3_b;
            1:       return lsu_pkg::funct3_h;
            2:       return lsu_pkg::funct3_w;
            3:       return lsu_pkg::funct3_bu;
            default: return lsu_pkg::funct3_hu;
        endcase
    endfunction

    function automatic dmem_pkg::data_t expect_load(input dmem_pkg::addr_t a,
                                                    input lsu_pkg::funct3_t f3);
        case (f3)
            lsu_pkg::funct3_b:  return {{24{ref_mem[a][7]}}, ref_mem[a]};
            lsu_pkg::funct3_bu: return {24'h0, ref_mem[a]};
            lsu_pkg::funct3_h:  return {{16{ref_mem[a+1][7]}}, ref_mem[a+1], ref_mem[a]};
            lsu_pkg::funct3_hu: return {16'h0, ref_mem[a+1], ref_mem[a]};
            default:            return {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
        endcase
    endfunction

    task automatic check_load(input lsu_pkg::tag_t exp_tag, input dmem_pkg::data_t exp_data);
        if (load_tag !== exp_tag || load_data !== exp_data) begin
            mismatches++;
            $display("Mismatch at %0d ns: load tag %0d data %h, expected tag %0d data %h",
                     $time, load_tag, load_data, exp_tag, exp_data);
        end
    endtask

    task automatic check_ready(input logic exp_ready);
        if (issue_ready !== exp_ready) begin
            mismatches++;
            $display("Mismatch at %0d ns: issue_ready %b, expected %b",
                     $time, issue_ready, exp_ready);
        end
    endtask

    task automatic drive_issue(input lsu_pkg::instr_u w, input dmem_pkg::data_t base,
                               input dmem_pkg::data_t data, input lsu_pkg::tag_t t);
        instr       = w;
        rs1_val     = base;
        rs2_val     = data;
        tag         = t;
        issue_valid = 1'b1;
    endtask

    // transfer happens on the edge after ready is seen high.
    task automatic finish_issue();
        @(negedge clk);
        while (!issue_ready) @(negedge clk);
        @(posedge clk);
        #1 issue_valid = 1'b0;
    endtask

    task automatic record_store(input dmem_pkg::addr_t addr, input lsu_pkg::funct3_t f3,
                                input dmem_pkg::data_t data);
        pend_addr.push_back(addr);
        pend_size.push_back(1 << f3[1:0]);
        pend_data.push_back(data);
    endtask

    task automatic send_store(input lsu_pkg::funct3_t f3, input dmem_pkg::addr_t addr,
                              input logic [11:0] imm, input dmem_pkg::data_t data);
        drive_issue(encode_store(f3, imm), base_for(addr, imm), data, '0);
        finish_issue();
        record_store(addr, f3, data);
    endtask

    task automatic commit_store();
        commit = 1'b1;
        @(posedge clk);
        #1 commit = 1'b0;
        for (int i = 0; i < pend_size[0]; i++) begin
            ref_mem[pend_addr[0] + i] = pend_data[0][8*i +: 8]; // little endian lanes.
        end
        void'(pend_addr.pop_front());
        void'(pend_size.pop_front());
        void'(pend_data.pop_front());
    endtask

    task automatic commit_all();
        while (pend_addr.size() > 0) commit_store();
    endtask

    task automatic pulse_flush();
        backend_flush = 1'b1;
        @(posedge clk);
        #1 backend_flush = 1'b0;
        pend_addr.delete();
        pend_size.delete();
        pend_data.delete();
    endtask

    task automatic run_load(input lsu_pkg::funct3_t f3, input dmem_pkg::addr_t addr,
                            input logic [11:0] imm);
        lsu_pkg::tag_t   t;
        dmem_pkg::data_t expected;
        int              wait_cycles;
        t           = next_tag;
        next_tag    = next_tag + 1'b1;
        expected    = expect_load(addr, f3);
        wait_cycles = 0;
        drive_issue(encode_load(f3, imm), base_for(addr, imm), $urandom, t);
        finish_issue();
        @(negedge clk);
        while (!load_done && wait_cycles < 50) begin
            wait_cycles++;
            @(negedge clk);
        end
        if (load_done) begin
            check_load(t, expected);
        end else begin
            failures++;
            $display("Error at %0d ns: load with tag %0d never completed", $time, t);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic word_roundtrip();
        send_store(lsu_pkg::funct3_w, 32'h100, 12'hffc, 32'h1234_5678);
        commit_store();
        run_load(lsu_pkg::funct3_w, 32'h100, 12'h010);
    endtask

    task automatic subword_merge();
        for (int i = 0; i < 4; i++) begin
            send_store(lsu_pkg::funct3_w, 32'h80 + 4*i, 12'h0, $urandom);
            commit_store();
            send_store(lsu_pkg::funct3_b, 32'h80 + 5*i, 12'h0, 32'h4c93_27f1 >> (8*i));
            commit_store();
        end
        for (int i = 0; i < 2; i++) begin
            send_store(lsu_pkg::funct3_w, 32'h90 + 4*i, 12'h0, $urandom);
            commit_store();
            send_store(lsu_pkg::funct3_h, 32'h90 + 6*i, 12'h0,
                       i ? 32'h0000_8abc : 32'hdead_7f31);
            commit_store();
        end
        for (int a = 32'h80; a < 32'h90; a++) begin
            run_load(lsu_pkg::funct3_b, a, 12'h0);
            run_load(lsu_pkg::funct3_bu, a, 12'h0);
        end
        for (int a = 32'h90; a < 32'h98; a += 2) begin
            run_load(lsu_pkg::funct3_h, a, 12'h0);
            run_load(lsu_pkg::funct3_hu, a, 12'h0);
        end
        for (int a = 32'h80; a < 32'h98; a += 4) run_load(lsu_pkg::funct3_w, a, 12'h0);
    endtask

    task automatic queue_backpressure();
        for (int i = 0; i < stq_depth; i++) begin
            send_store(lsu_pkg::funct3_w, 32'h200 + 4*i, 12'h0, $urandom);
        end
        drive_issue(encode_store(lsu_pkg::funct3_w, 12'h0), 32'h200 + 4*stq_depth,
                    32'hcafe_f00d, '0);
        repeat (2) begin
            @(negedge clk);
            check_ready(1'b0);
        end
        @(posedge clk);
        #1;
        commit_store();
        finish_issue();
        record_store(32'h200 + 4*stq_depth, lsu_pkg::funct3_w, 32'hcafe_f00d);
        commit_all();
        run_load(lsu_pkg::funct3_w, 32'h200 + 4*stq_depth, 12'h0);
    endtask

    task automatic flush_drop();
        int late_done;
        late_done = 0;
        send_store(lsu_pkg::funct3_w, 32'h300, 12'h0, 32'h600d_600d);
        commit_store();
        send_store(lsu_pkg::funct3_w, 32'h300, 12'h0, 32'hbad0_bad0);
        send_store(lsu_pkg::funct3_b, 32'h301, 12'h0, 32'h0000_00ee);
        pulse_flush();
        run_load(lsu_pkg::funct3_w, 32'h300, 12'h0);
        // load goes to memory one cycle after issue, then the flush hits it.
        drive_issue(encode_load(lsu_pkg::funct3_w, 12'h0), 32'h300, '0, 4'hf);
        finish_issue();
        @(posedge clk);
        #1;
        pulse_flush();
        repeat (mem_latency + 4) begin
            @(negedge clk);
            if (load_done) late_done++;
        end
        if (late_done != 0) begin
            failures++;
            $display("Error at %0d ns: a load flushed in flight still reported a result", $time);
        end
        @(posedge clk);
        #1;
        run_load(lsu_pkg::funct3_w, 32'h300, 12'h0);
    endtask

    task automatic random_mix();
        dmem_pkg::addr_t  a;
        lsu_pkg::funct3_t f3;
        logic [11:0]      imm;
        for (int i = 0; i < 16; i++) begin
            send_store(lsu_pkg::funct3_w, 4*i, 12'h0, $urandom);
            commit_store();
        end
        for (int n = 0; n < 200; n++) begin
            imm = 12'($urandom % 128) - 12'd64;
            f3  = random_funct3(($urandom % 2) ? 3 : 5);
            a   = (($urandom % 64) >> f3[1:0]) << f3[1:0];
            if (f3 inside {lsu_pkg::funct3_b, lsu_pkg::funct3_h, lsu_pkg::funct3_w}
                && ($urandom % 2)) begin
                send_store(f3, a, imm, $urandom);
                if (pend_addr.size() == stq_depth || $urandom % 3 == 0) commit_store();
            end else begin
                commit_all(); // loads wait for an empty queue.
                run_load(f3, a, imm);
            end
        end
        commit_all();
    endtask

    initial begin
        void'($urandom(32'h00bc55f0));
        rst           = 1'b1;
        issue_valid   = 1'b0;
        instr         = '0;
        rs1_val       = '0;
        rs2_val       = '0;
        tag           = '0;
        commit        = 1'b0;
        backend_flush = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        word_roundtrip();
        subword_merge();
        queue_backpressure();
        flush_drop();
        random_mix();
        $display("run complete: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("Error: run did not finish within %0d ns", watchdog_ns);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== verilog/dmem_arbiter.sv ====
module dmem_arbiter (
    input  logic            clk,
    input  logic            rst,
    input  logic            backend_flush,

    input  logic            load_valid,
    output logic            load_ready,
    input  dmem_pkg::addr_t load_addr,
    input  dmem_pkg::mask_t load_rmask,
    output dmem_pkg::data_t load_rdata,
    output logic            load_resp,

    input  logic            store_valid,
    output logic            store_ready,
    input  dmem_pkg::addr_t store_addr,
    input  dmem_pkg::mask_t store_wmask,
    input  dmem_pkg::data_t store_wdata,

    output dmem_pkg::addr_t mem_addr,
    output dmem_pkg::mask_t mem_rmask,
    output dmem_pkg::mask_t mem_wmask,
    output dmem_pkg::data_t mem_wdata,
    input  dmem_pkg::data_t mem_rdata,
    input  logic            mem_resp
);

    logic load_xfer;
    logic store_xfer;
    logic pending;
    logic pending_store;
    logic flushed;
    logic busy;

    assign busy = pending && !mem_resp; // free again in the response cycle.

    assign store_ready = !busy && !flushed;
    assign load_ready  = !busy && !flushed && !store_valid; // stores first.

    assign load_xfer  = load_valid && load_ready;
    assign store_xfer = store_valid && store_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending       <= 1'b0;
            pending_store <= 1'b0;
        end else if (load_xfer || store_xfer) begin
            pending       <= 1'b1;
            pending_store <= store_xfer;
        end else if (mem_resp) begin
            pending       <= 1'b0;
            pending_store <= 1'b0;
        end
    end

    // a load in flight at flush time, including one sent in the flush cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            flushed <= 1'b0;
        end else if (backend_flush && (busy || load_xfer)) begin
            flushed <= 1'b1;
        end else if (mem_resp) begin
            flushed <= 1'b0;
        end
    end

    assign mem_rmask = load_xfer ? load_rmask : '0;
    assign mem_wmask = store_xfer ? store_wmask : '0;
    assign mem_addr  = store_valid ? store_addr : load_addr;
    assign mem_wdata = store_wdata;

    assign load_rdata = mem_rdata;
    assign load_resp  = mem_resp && pending && !pending_store && !flushed;

endmodule

// ==== verilog/dmem_model.sv ====
module dmem_model #(
    parameter int MEM_WORDS   = 256,
    parameter int MEM_LATENCY = 2
) (
    input  logic            clk,
    input  logic            rst,
    input  dmem_pkg::addr_t mem_addr,
    input  dmem_pkg::mask_t mem_rmask,
    input  dmem_pkg::mask_t mem_wmask,
    input  dmem_pkg::data_t mem_wdata,
    output dmem_pkg::data_t mem_rdata,
    output logic            mem_resp
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    dmem_pkg::data_t  mem [MEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             req;

    logic [MEM_LATENCY-1:0] resp_q; // response delay line.
    dmem_pkg::data_t        rdata_q [MEM_LATENCY];

    assign idx = mem_addr[IDX_W+1:2];
    assign req = (mem_rmask != '0) || (mem_wmask != '0);

    always_ff @(posedge clk) begin
        for (int i = 0; i < dmem_pkg::mask_width; i++) begin
            if (mem_wmask[i]) begin
                mem[idx][8*i +: 8] <= mem_wdata[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_q <= '0;
        end else begin
            for (int i = MEM_LATENCY - 1; i > 0; i--) begin
                resp_q[i] <= resp_q[i-1];
            end
            resp_q[0] <= req;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = MEM_LATENCY - 1; i > 0; i--) begin
            rdata_q[i] <= rdata_q[i-1];
        end
        rdata_q[0] <= mem[idx]; // read at request time.
    end

    assign mem_resp  = resp_q[MEM_LATENCY-1];
    assign mem_rdata = rdata_q[MEM_LATENCY-1];

endmodule

// ==== verilog/dmem_pkg.sv ====
package dmem_pkg;

    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int mask_width = data_width / 8;

    typedef logic [addr_width-1:0] addr_t;
    typedef logic [data_width-1:0] data_t;

    // one bit per byte lane; all zero means no request.
    typedef logic [mask_width-1:0] mask_t;

endpackage

// ==== verilog/load_unit.sv ====
module load_unit (
    input  logic             clk,
    input  logic             rst,
    input  logic             backend_flush,

    input  logic             ld_valid,
    output logic             ld_ready,
    input  dmem_pkg::addr_t  op_addr,
    input  lsu_pkg::funct3_t op_funct3,
    input  lsu_pkg::tag_t    op_tag,
    input  logic             stq_empty,

    output logic             load_valid,
    input  logic             load_ready,
    output dmem_pkg::addr_t  load_addr,
    output dmem_pkg::mask_t  load_rmask,
    input  dmem_pkg::data_t  load_rdata,
    input  logic             load_resp,

    output logic             load_done,
    output lsu_pkg::tag_t    load_tag,
    output dmem_pkg::data_t  load_data
);

    localparam logic [1:0] st_empty = 2'd0;
    localparam logic [1:0] st_wait  = 2'd1;
    localparam logic [1:0] st_sent  = 2'd2;

    logic [1:0]       state;
    dmem_pkg::addr_t  addr_q;
    lsu_pkg::funct3_t funct3_q;
    dmem_pkg::data_t  lane;
    dmem_pkg::data_t  ext_data;

    always_ff @(posedge clk) begin
        if (rst || backend_flush) begin
            state <= st_empty;
        end else begin
            case (state)
                st_empty: if (ld_valid) state <= st_wait;
                st_wait:  if (load_valid && load_ready) state <= st_sent;
                st_sent:  if (load_resp) state <= st_empty;
                default:  state <= st_empty;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ld_valid && ld_ready) begin
            addr_q   <= op_addr;
            funct3_q <= op_funct3;
            load_tag <= op_tag;
        end
    end

    assign ld_ready   = state == st_empty;
    assign load_valid = (state == st_wait) && stq_empty; // no forwarding, so wait for stores.
    assign load_addr  = addr_q;
    assign load_rmask = 4'b1111; // whole word is read, lanes picked on return.

    assign lane = load_rdata >> {addr_q[1:0], 3'b000};

    always_comb begin
        case (funct3_q)
            lsu_pkg::funct3_b:  ext_data = {{24{lane[7]}}, lane[7:0]};
            lsu_pkg::funct3_bu: ext_data = {24'h0, lane[7:0]};
            lsu_pkg::funct3_h:  ext_data = {{16{lane[15]}}, lane[15:0]};
            lsu_pkg::funct3_hu: ext_data = {16'h0, lane[15:0]};
            default:            ext_data = load_rdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            load_done <= 1'b0;
        end else begin
            load_done <= (state == st_sent) && load_resp && !backend_flush;
        end
    end

    always_ff @(posedge clk) begin
        load_data <= ext_data;
    end

endmodule

// ==== verilog/lsu_pkg.sv ====
package lsu_pkg;

    localparam int opcode_width = 7;
    localparam int funct3_width = 3;
    localparam int tag_width    = 4;

    localparam logic [opcode_width-1:0] opcode_load  = 7'b0000011;
    localparam logic [opcode_width-1:0] opcode_store = 7'b0100011;

    // size in bits [1:0], bit 2 set for zero extension.
    typedef enum logic [funct3_width-1:0] {
        funct3_b  = 3'b000,
        funct3_h  = 3'b001,
        funct3_w  = 3'b010,
        funct3_bu = 3'b100,
        funct3_hu = 3'b101
    } funct3_t;

    typedef logic [tag_width-1:0] tag_t;

    // one instruction word, read as a load (i_view) or as a store (s_view).
    typedef union packed {
        struct packed {
            logic [11:0]             imm;
            logic [4:0]              rs1;
            logic [funct3_width-1:0] funct3;
            logic [4:0]              rd;
            logic [opcode_width-1:0] opcode;
        } i_view;
        struct packed {
            logic [6:0]              imm_hi;
            logic [4:0]              rs2;
            logic [4:0]              rs1;
            logic [funct3_width-1:0] funct3;
            logic [4:0]              imm_lo;
            logic [opcode_width-1:0] opcode;
        } s_view;
    } instr_u;

endpackage

// ==== verilog/lsu_top.sv ====
module lsu_top #(
    parameter int STQ_DEPTH   = 4,
    parameter int MEM_WORDS   = 256,
    parameter int MEM_LATENCY = 2
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            issue_valid,
    output logic            issue_ready,
    input  lsu_pkg::instr_u instr,
    input  dmem_pkg::data_t rs1_val,
    input  dmem_pkg::data_t rs2_val,
    input  lsu_pkg::tag_t   tag,
    input  logic            commit,
    input  logic            backend_flush,
    output logic            load_done,
    output lsu_pkg::tag_t   load_tag,
    output dmem_pkg::data_t load_data
);

    logic             ld_valid, ld_ready, st_valid, st_ready, stq_empty;
    dmem_pkg::addr_t  op_addr;
    lsu_pkg::funct3_t op_funct3;
    lsu_pkg::tag_t    op_tag;
    dmem_pkg::mask_t  op_wmask;
    dmem_pkg::data_t  op_wdata;

    logic             load_valid, load_ready, load_resp;
    dmem_pkg::addr_t  load_addr;
    dmem_pkg::mask_t  load_rmask;
    dmem_pkg::data_t  load_rdata;

    logic             store_valid, store_ready;
    dmem_pkg::addr_t  store_addr;
    dmem_pkg::mask_t  store_wmask;
    dmem_pkg::data_t  store_wdata;

    dmem_pkg::addr_t  mem_addr;
    dmem_pkg::mask_t  mem_rmask, mem_wmask;
    dmem_pkg::data_t  mem_wdata, mem_rdata;
    logic             mem_resp;

    mem_op_decode u_decode (.*);

    load_unit u_load (.*);

    store_queue #(.STQ_DEPTH(STQ_DEPTH)) u_stq (.*);

    dmem_arbiter u_arb (.*);

    dmem_model #(.MEM_WORDS(MEM_WORDS), .MEM_LATENCY(MEM_LATENCY)) u_mem (.*);

endmodule

// ==== verilog/mem_op_decode.sv ====
module mem_op_decode (
    input  logic             issue_valid,
    output logic             issue_ready,
    input  lsu_pkg::instr_u  instr,
    input  dmem_pkg::data_t  rs1_val,
    input  dmem_pkg::data_t  rs2_val,
    input  lsu_pkg::tag_t    tag,

    output logic             ld_valid,
    input  logic             ld_ready,
    output logic             st_valid,
    input  logic             st_ready,

    output dmem_pkg::addr_t  op_addr,
    output lsu_pkg::funct3_t op_funct3,
    output lsu_pkg::tag_t    op_tag,
    output dmem_pkg::mask_t  op_wmask,
    output dmem_pkg::data_t  op_wdata
);

    logic            is_load;
    logic            is_store;
    dmem_pkg::data_t imm;
    dmem_pkg::addr_t raw_addr;

    assign is_load  = instr.i_view.opcode == lsu_pkg::opcode_load;
    assign is_store = instr.s_view.opcode == lsu_pkg::opcode_store;

    assign op_funct3 = lsu_pkg::funct3_t'(instr.i_view.funct3);

    assign imm = is_store ? {{20{instr.s_view.imm_hi[6]}}, instr.s_view.imm_hi,
                             instr.s_view.imm_lo}
                          : {{20{instr.i_view.imm[11]}}, instr.i_view.imm};

    assign raw_addr = rs1_val + imm;

    always_comb begin
        case (op_funct3[1:0])
            2'b00: begin
                op_addr  = raw_addr;
                op_wmask = 4'b0001 << raw_addr[1:0];
            end
            2'b01: begin
                op_addr  = {raw_addr[31:1], 1'b0}; // halfword aligned.
                op_wmask = 4'b0011 << {raw_addr[1], 1'b0};
            end
            default: begin
                op_addr  = {raw_addr[31:2], 2'b00};
                op_wmask = 4'b1111;
            end
        endcase
    end

    assign op_wdata = rs2_val << {op_addr[1:0], 3'b000};
    assign op_tag   = tag;

    // anything that is neither load nor store is taken and dropped.
    assign issue_ready = is_load ? ld_ready : (is_store ? st_ready : 1'b1);
    assign ld_valid    = issue_valid && is_load && ld_ready;
    assign st_valid    = issue_valid && is_store && st_ready;

endmodule

// ==== verilog/store_queue.sv ====
module store_queue #(
    parameter int STQ_DEPTH = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            backend_flush,
    input  logic            commit,

    input  logic            st_valid,
    output logic            st_ready,
    input  dmem_pkg::addr_t op_addr,
    input  dmem_pkg::mask_t op_wmask,
    input  dmem_pkg::data_t op_wdata,
    output logic            stq_empty,

    output logic            store_valid,
    input  logic            store_ready,
    output dmem_pkg::addr_t store_addr,
    output dmem_pkg::mask_t store_wmask,
    output dmem_pkg::data_t store_wdata
);

    localparam int PTR_W = (STQ_DEPTH > 1) ? $clog2(STQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(STQ_DEPTH + 1);

    dmem_pkg::addr_t addr_mem [STQ_DEPTH];
    dmem_pkg::mask_t mask_mem [STQ_DEPTH];
    dmem_pkg::data_t data_mem [STQ_DEPTH];

    logic [PTR_W-1:0] head_ptr;
    logic [PTR_W-1:0] commit_ptr;
    logic [PTR_W-1:0] tail_ptr;
    logic [PTR_W-1:0] commit_ptr_next;
    logic [CNT_W-1:0] used;    // all entries.
    logic [CNT_W-1:0] cmt_cnt; // committed, not yet written.
    logic [CNT_W-1:0] cmt_cnt_next;
    logic             push;
    logic             pop;
    logic             commit_ok;

    function automatic logic [PTR_W-1:0] inc_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(STQ_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push      = st_valid && st_ready;
    assign pop       = store_valid && store_ready;
    assign commit_ok = commit && (used != cmt_cnt); // a commit with nothing to commit is ignored.

    assign commit_ptr_next = commit_ok ? inc_ptr(commit_ptr) : commit_ptr;
    assign cmt_cnt_next    = cmt_cnt + CNT_W'(commit_ok) - CNT_W'(pop);

    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr   <= '0;
            commit_ptr <= '0;
            tail_ptr   <= '0;
            used       <= '0;
            cmt_cnt    <= '0;
        end else begin
            head_ptr   <= pop ? inc_ptr(head_ptr) : head_ptr;
            commit_ptr <= commit_ptr_next;
            cmt_cnt    <= cmt_cnt_next;
            if (backend_flush) begin
                // uncommitted entries are dropped.
                tail_ptr <= commit_ptr_next;
                used     <= cmt_cnt_next;
            end else begin
                tail_ptr <= push ? inc_ptr(tail_ptr) : tail_ptr;
                used     <= used + CNT_W'(push) - CNT_W'(pop);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[tail_ptr] <= op_addr;
            mask_mem[tail_ptr] <= op_wmask;
            data_mem[tail_ptr] <= op_wdata;
        end
    end

    assign st_ready    = used != CNT_W'(STQ_DEPTH);
    assign stq_empty   = used == '0;
    assign store_valid = cmt_cnt != '0; // head goes out only once committed.
    assign store_addr  = addr_mem[head_ptr];
    assign store_wmask = mask_mem[head_ptr];
    assign store_wdata = data_mem[head_ptr];

endmodule
